//--- design/receptor_macros.svh
// ######################################
// Widths and fixed code-group values for the 1000BASE-X receive path
// Code groups are ten bits in transmission order abcdeifghj
// ######################################

`ifndef RECEPTOR_MACROS_SVH
`define RECEPTOR_MACROS_SVH

// ######################################
// Widths
// ######################################
`define CG_WIDTH 10         // One ten-bit code group
`define OCTET_WIDTH 8       // One GMII octet on rxd

// ######################################
// Fixed values
// ######################################
`define PREAMBLE_OCTET 8'h55        // Stands in for /S/ on rxd

// Comma group in both running disparities
`define K28_5_POS 10'b1100000101    // K28.5 at RD+
`define K28_5_NEG 10'b0011111010    // K28.5 at RD-

`endif

//--- design/receptor_pkg.sv
// ######################################
// Shared types of the receive path
// State encoding is one-hot, seven bits
// cg_info_t carries one classified code group, octet is zero
// for anything that is not a table data group
// ######################################

`include "receptor_macros.svh"

package receptor_pkg;

    // ######################################
    // Plain vector types
    // ######################################
    typedef logic [`CG_WIDTH-1:0]    code_group_t;  // Received ten-bit group
    typedef logic [`OCTET_WIDTH-1:0] octet_t;       // Decoded octet

    // ######################################
    // Receive FSM states
    // ######################################
    typedef enum logic [6:0] {
        LINK_FAILED     = 7'b0000001,   // Sync lost
        WAIT_FOR_K      = 7'b0000010,   // Hunting for an even comma
        RX_K            = 7'b0000100,   // Comma seen, expect data
        IDLE_D          = 7'b0001000,   // Idle data, also carrier detect
        START_OF_PACKET = 7'b0010000,   // Preamble on rxd
        RECEIVE         = 7'b0100000,   // Frame data
        TRI_RRI         = 7'b1000000    // End sequence seen
    } rx_state_e;

    // ######################################
    // Classified code group
    // ######################################
    typedef struct packed {
        logic   is_data;        // Data group from the table
        logic   is_comma;       // K28.5
        logic   is_start;       // K27.7, /S/
        logic   is_term;        // K29.7, /T/
        logic   is_carrier_ext; // K23.7, /R/
        octet_t octet;          // Decoded value
    } cg_info_t;

endpackage

//--- design/code_group_decoder.sv
// ######################################
// Combinational lookup of one code group
// Only fourteen data groups are known, both disparities
// Unknown groups give all flags low and a zero octet
// No disparity or code violation checking
// ######################################

`include "receptor_macros.svh"

module code_group_decoder (
    input  receptor_pkg::code_group_t code_in,  // Group straight from SUDI
    output receptor_pkg::cg_info_t    info      // Flags and octet
);

    // Special groups used for framing
    localparam receptor_pkg::code_group_t K27_7_NEG = 10'b1101101000;  // /S/
    localparam receptor_pkg::code_group_t K27_7_POS = 10'b0010010111;
    localparam receptor_pkg::code_group_t K29_7_NEG = 10'b1011101000;  // /T/
    localparam receptor_pkg::code_group_t K29_7_POS = 10'b0100010111;
    localparam receptor_pkg::code_group_t K23_7_NEG = 10'b1110101000;  // /R/
    localparam receptor_pkg::code_group_t K23_7_POS = 10'b0001010111;

    logic                 data_hit;     // Group found in the data table
    receptor_pkg::octet_t data_octet;   // Its octet

    // ######################################
    // Data table
    // ######################################
    always_comb begin
        data_hit   = 1'b1;
        data_octet = '0;
        case (code_in)
            10'b1001110100, 10'b0110001011: data_octet = 8'h00; // D0.0
            10'b0101101011, 10'b0101100100: data_octet = 8'h1a; // D26.0
            10'b0101111001, 10'b1010001001: data_octet = 8'h2f; // D15.1
            10'b1110010101, 10'b0001100101: data_octet = 8'h48; // D8.2
            10'b1110100101, 10'b0001010101: data_octet = 8'h57; // D23.2
            10'b1100101100, 10'b1100100011: data_octet = 8'h73; // D19.3
            10'b1100011101, 10'b1100010010: data_octet = 8'h83; // D3.4
            10'b1101001010:                 data_octet = 8'hab; // D11.5, neutral
            10'b0110010110:                 data_octet = 8'hc6; // D6.6, neutral
            10'b1001011011, 10'b1001010100: data_octet = 8'h09; // D9.0
            10'b1010010110:                 data_octet = 8'hc5; // D5.6, neutral
            10'b0110011010:                 data_octet = 8'ha6; // D6.5, neutral
            10'b0101101101, 10'b0101100010: data_octet = 8'h9a; // D26.4
            10'b0110110101, 10'b1001000101: data_octet = 8'h50; // D16.2, idle data
            default: begin
                data_hit = 1'b0;    // Not a known data group
            end
        endcase
    end

    // ######################################
    // Class flags
    // ######################################
    assign info.is_data        = data_hit;
    assign info.octet          = data_octet;
    assign info.is_comma       = (code_in == `K28_5_POS) || (code_in == `K28_5_NEG);
    assign info.is_start       = (code_in == K27_7_POS) || (code_in == K27_7_NEG);
    assign info.is_term        = (code_in == K29_7_POS) || (code_in == K29_7_NEG);
    assign info.is_carrier_ext = (code_in == K23_7_POS) || (code_in == K23_7_NEG);

endmodule

//--- design/code_group_history.sv
// ######################################
// Three-deep history of classified groups
// cur_cg lags the input by one cycle, prev_cg by two
// end_seen flags /T/R/K28.5 across the three stages
// ######################################

module code_group_history (
    input  logic                   clk_receptor,
    input  logic                   rst_n,       // Sync, active low
    input  receptor_pkg::cg_info_t info_in,     // From the decoder
    input  logic                   rx_even_in,  // Raw rx_even
    output receptor_pkg::cg_info_t cur_cg,      // Newest registered group
    output receptor_pkg::cg_info_t prev_cg,     // One before cur_cg
    output logic                   rx_even,     // Aligned with cur_cg
    output logic                   end_seen     // /T/ /R/ K28.5 in order
);

    receptor_pkg::cg_info_t oldest_cg;  // Two before cur_cg

    // ######################################
    // Shift stages
    // ######################################
    always_ff @(posedge clk_receptor) begin
        if (!rst_n) begin
            cur_cg    <= '0;
            prev_cg   <= '0;
            oldest_cg <= '0;
            rx_even   <= 1'b0;
        end else begin
            cur_cg    <= info_in;       // Stage 1
            prev_cg   <= cur_cg;        // Stage 2
            oldest_cg <= prev_cg;       // Stage 3
            rx_even   <= rx_even_in;    // Keep parity lined up with cur_cg
        end
    end

    // End of packet sequence, oldest first
    assign end_seen = oldest_cg.is_term
                    & prev_cg.is_carrier_ext
                    & cur_cg.is_comma;

endmodule

//--- design/receive_fsm.sv
// ######################################
// Receive FSM that drives rxd, rx_dv and rx_er
// All outputs are registered and rxd lags cur_cg by one cycle
// Non-data groups inside a frame hold rxd
// rx_er only marks a sync loss in the middle of a frame
// ######################################

`include "receptor_macros.svh"

module receive_fsm (
    input  logic                   clk_receptor,
    input  logic                   rst_n,       // Synchronous active low reset
    input  logic                   sync_status, // High while synchronized
    input  receptor_pkg::cg_info_t cur_cg,      // Newest group
    input  receptor_pkg::cg_info_t prev_cg,     // Group before it
    input  logic                   rx_even,     // Low on even position
    input  logic                   end_seen,    // /T/R/K28.5 found
    output receptor_pkg::octet_t   rxd,
    output logic                   rx_dv,
    output logic                   rx_er
);

    receptor_pkg::rx_state_e state;
    receptor_pkg::rx_state_e next_state;
    receptor_pkg::octet_t    next_rxd;
    logic                    receiving;     // Frame in progress
    logic                    comma_seen;    // Comma in either stage
    logic                    data_seen;     // Data in either stage

    assign comma_seen = cur_cg.is_comma | prev_cg.is_comma;
    assign data_seen  = cur_cg.is_data | prev_cg.is_data;

    // ######################################
    // Next state and next octet
    // ######################################
    always_comb begin
        next_state = state;
        next_rxd   = rxd;   // Hold by default
        if (!sync_status) begin
            next_state = receptor_pkg::LINK_FAILED;    // Overrides every state
        end else begin
            case (state)
                receptor_pkg::LINK_FAILED: begin
                    next_state = receptor_pkg::WAIT_FOR_K;
                end
                receptor_pkg::WAIT_FOR_K: begin
                    if (!rx_even && comma_seen)
                        next_state = receptor_pkg::RX_K;
                end
                receptor_pkg::RX_K: begin
                    if (rx_even && data_seen)
                        next_state = receptor_pkg::IDLE_D;
                end
                receptor_pkg::IDLE_D: begin
                    if (comma_seen) begin
                        next_state = receptor_pkg::RX_K;
                    end else if (cur_cg.is_start) begin
                        next_state = receptor_pkg::START_OF_PACKET;
                        next_rxd   = `PREAMBLE_OCTET;  // /S/ shows as preamble
                    end
                end
                receptor_pkg::START_OF_PACKET: begin
                    next_state = receptor_pkg::RECEIVE;
                    next_rxd   = cur_cg.octet;         // First frame octet
                end
                receptor_pkg::RECEIVE: begin
                    if (end_seen && !rx_even)
                        next_state = receptor_pkg::TRI_RRI;
                    else if (cur_cg.is_data)
                        next_rxd = cur_cg.octet;       // /T/ and /R/ hold rxd
                end
                receptor_pkg::TRI_RRI: begin
                    if (!rx_even && comma_seen)
                        next_state = receptor_pkg::RX_K;
                end
                default: begin
                    next_state = receptor_pkg::WAIT_FOR_K;  // Recover from a bad code
                end
            endcase
        end
    end

    // ######################################
    // State and output registers
    // ######################################
    always_ff @(posedge clk_receptor) begin
        if (!rst_n) begin
            state     <= receptor_pkg::WAIT_FOR_K;
            rxd       <= '0;
            rx_dv     <= 1'b0;
            rx_er     <= 1'b0;
            receiving <= 1'b0;
        end else begin
            state <= next_state;
            rxd   <= next_rxd;
            rx_dv <= (next_state == receptor_pkg::START_OF_PACKET)
                  || (next_state == receptor_pkg::RECEIVE);
            // One pulse on entry to LINK_FAILED during a frame
            rx_er <= receiving && (next_state == receptor_pkg::LINK_FAILED);
            if (next_state == receptor_pkg::START_OF_PACKET)
                receiving <= 1'b1;
            else if ((next_state == receptor_pkg::TRI_RRI)
                  || (next_state == receptor_pkg::LINK_FAILED))
                receiving <= 1'b0;
        end
    end

endmodule

//--- design/receptor.sv
// ######################################
// PCS receive path top, SUDI in, GMII-like octets out
// Fixed latency of two cycles from sudi_receive to rxd
// No back-pressure, one group taken every cycle
// ######################################

module receptor (
    input  logic                      clk_receptor,
    input  logic                      rst_n,            // Sync, active low
    input  logic                      sync_status,      // Link synchronized
    input  receptor_pkg::code_group_t sudi_receive,     // One group per clock
    input  logic                      rx_even_receive,  // Low on first group of a set
    output receptor_pkg::octet_t      rxd,
    output logic                      rx_dv,
    output logic                      rx_er
);

    receptor_pkg::cg_info_t dec_info;   // Decoder result, not registered
    receptor_pkg::cg_info_t cur_cg;
    receptor_pkg::cg_info_t prev_cg;
    logic                   rx_even;
    logic                   end_seen;

    code_group_decoder u_decoder (
        .code_in (sudi_receive),
        .info    (dec_info)
    );

    code_group_history u_history (
        .clk_receptor (clk_receptor),
        .rst_n        (rst_n),
        .info_in      (dec_info),
        .rx_even_in   (rx_even_receive),
        .cur_cg       (cur_cg),
        .prev_cg      (prev_cg),
        .rx_even      (rx_even),
        .end_seen     (end_seen)
    );

    receive_fsm u_fsm (
        .clk_receptor (clk_receptor),
        .rst_n        (rst_n),
        .sync_status  (sync_status),
        .cur_cg       (cur_cg),
        .prev_cg      (prev_cg),
        .rx_even      (rx_even),
        .end_seen     (end_seen),
        .rxd          (rxd),
        .rx_dv        (rx_dv),
        .rx_er        (rx_er)
    );

endmodule

//--- dv/receptor_properties.sv
// ######################################
// Assertions on the receive FSM outputs
// Bound to receive_fsm from the testbench top
// ######################################

`include "receptor_macros.svh"

module receptor_properties (
    input logic                 clk_receptor,
    input logic                 rst_n,
    input logic                 sync_status,
    input receptor_pkg::octet_t rxd,
    input logic                 rx_dv,
    input logic                 rx_er
);

    // Outputs cleared by reset
    a_reset_clear: assert property (@(posedge clk_receptor)
        !rst_n |=> (!rx_dv && !rx_er))
        else $error("rx_dv or rx_er high after reset");

    // A burst opens with the preamble
    a_dv_preamble: assert property (@(posedge clk_receptor) disable iff (!rst_n)
        $rose(rx_dv) |-> (rxd == `PREAMBLE_OCTET))
        else $error("rx_dv rose without the preamble octet on rxd");

    // rx_er only follows a sync loss
    a_er_sync: assert property (@(posedge clk_receptor) disable iff (!rst_n)
        rx_er |-> !$past(sync_status))
        else $error("rx_er high without a sync loss the cycle before");

endmodule

//--- dv/receptor_clock.sv
// ######################################
// Clock and synchronous reset for the testbench
// rst_n is released on a rising edge
// ######################################

module receptor_clock #(
    parameter int period       = 100,  // Clock period in time units
    parameter int reset_cycles = 4     // Cycles with rst_n low
) (
    output logic clk_receptor,
    output logic rst_n
);

    initial begin
        clk_receptor = 1'b0;
        rst_n        = 1'b0;
        repeat (reset_cycles) @(posedge clk_receptor);
        rst_n <= 1'b1;                      // Leave reset after the edge
    end

    always #(period / 2) clk_receptor = ~clk_receptor;

endmodule

//--- dv/receptor_checker.sv
// ######################################
// Watches rxd, rx_dv and rx_er and compares bursts
// One expected burst is pending at a time
// A prefix burst must end early but match so far
// ######################################

module receptor_checker (
    input logic                 clk_receptor,
    input logic                 rst_n,
    input receptor_pkg::octet_t rxd,
    input logic                 rx_dv,
    input logic                 rx_er
);

    receptor_pkg::octet_t got_q[$];     // Octets of the running burst
    receptor_pkg::octet_t exp_q[$];     // Expected burst
    string                exp_name;
    bit                   exp_valid;
    bit                   exp_prefix;   // Truncation expected
    int bursts_done, dv_cycles, er_cycles, rxd_busy_cycles;
    int n_errors, n_tests, n_failed, errors_mark;

    task automatic expect_burst(input string name, input bit prefix,
                                input receptor_pkg::octet_t exp[$]);
        exp_q      = exp;
        exp_name   = name;
        exp_prefix = prefix;
        exp_valid  = 1'b1;
    endtask

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error %s: %s expected %0d actual %0d", name, what, expected, actual);
            n_errors++;
        end
    endtask

    task automatic compare_burst();
        int limit;
        if (!exp_valid) begin
            $display("A burst of %0d octets arrived with no packet sent", got_q.size());
            n_errors++;
            return;
        end
        if (exp_prefix) begin
            if (got_q.size() >= exp_q.size()) begin
                $display("Burst in %s did not end early on the sync loss", exp_name);
                n_errors++;
            end
        end else begin
            check_value(exp_name, "burst length", exp_q.size(), got_q.size());
        end
        limit = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < limit; i++) begin
            if (got_q[i] != exp_q[i]) begin
                $display("** Error %s: octet %0d expected %h actual %h",
                         exp_name, i, exp_q[i], got_q[i]);
                n_errors++;
            end
        end
        exp_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (n_errors != errors_mark) begin
            n_failed++;
            $display("FAIL %s", name);
        end else begin
            $display("PASS %s", name);
        end
        errors_mark = n_errors;
    endtask

    task automatic report_counts();
        $display("Tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
    endtask

    // ######################################
    // Burst collection
    // ######################################
    always @(posedge clk_receptor) begin
        if (rst_n) begin
            dv_cycles       += rx_dv;
            er_cycles       += rx_er;
            rxd_busy_cycles += (rxd != '0);    // Any octet ever shown
            if (rx_dv) begin
                got_q.push_back(rxd);
            end else if (got_q.size() > 0) begin
                compare_burst();               // rx_dv just fell
                got_q.delete();
                bursts_done++;
            end
        end
    end

endmodule

//--- dv/tb_receptor.sv
// ######################################
// Testbench top for the receptor PCS receive path
// rx_even alternates every group and /S/ is padded so K28.5 lands even
// Data groups come from a local 8b/10b table
// ######################################

`include "receptor_macros.svh"

module tb_receptor;

    typedef receptor_pkg::octet_t octet_q_t[$];
    typedef receptor_pkg::code_group_t cg_t;

    localparam cg_t D16_2 = 10'b0110110101;    // Idle data
    localparam cg_t K27_7 = 10'b1101101000;    // /S/
    localparam cg_t K29_7 = 10'b1011101000;    // /T/
    localparam cg_t K23_7 = 10'b1110101000;    // /R/
    localparam cg_t CG_NEG [13] = '{10'b1001110100, 10'b0101101011, 10'b0101111001,
        10'b1110010101, 10'b1110100101, 10'b1100101100, 10'b1100011101, 10'b1101001010,
        10'b0110010110, 10'b1001011011, 10'b1010010110, 10'b0110011010, 10'b0101101101};
    localparam cg_t CG_POS [13] = '{10'b0110001011, 10'b0101100100, 10'b1010001001,
        10'b0001100101, 10'b0001010101, 10'b1100100011, 10'b1100010010, 10'b1101001010,
        10'b0110010110, 10'b1001010100, 10'b1010010110, 10'b0110011010, 10'b0101100010};
    // D0.0 D26.0 D15.1 D8.2 D23.2 D19.3 D3.4 D11.5 D6.6 D9.0 D5.6 D6.5 D26.4
    localparam receptor_pkg::octet_t OCT [13] = '{8'h00, 8'h1a, 8'h2f, 8'h48, 8'h57,
        8'h73, 8'h83, 8'hab, 8'hc6, 8'h09, 8'hc5, 8'ha6, 8'h9a};

    logic clk_receptor, rst_n, sync_status, rx_even_receive, rx_dv, rx_er;
    cg_t                  sudi_receive;
    receptor_pkg::octet_t rxd;
    bit                   odd;      // Parity of the next group
    int                   mark;

    receptor_clock #(.period(100), .reset_cycles(4)) clk0 (.clk_receptor, .rst_n);
    receptor dut0 (.clk_receptor, .rst_n, .sync_status, .sudi_receive,
                   .rx_even_receive, .rxd, .rx_dv, .rx_er);
    receptor_checker chk0 (.clk_receptor, .rst_n, .rxd, .rx_dv, .rx_er);
    bind receive_fsm receptor_properties props0 (.clk_receptor, .rst_n, .sync_status,
                                                 .rxd, .rx_dv, .rx_er);

    // Preamble then the frame octets then the last octet held for /T/ and /R/
    function automatic octet_q_t expected_burst(input octet_q_t data);
        octet_q_t burst;
        burst.push_back(`PREAMBLE_OCTET);
        foreach (data[i]) burst.push_back(data[i]);
        repeat (2) burst.push_back(data[data.size()-1]);
        return burst;
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        chk0.n_errors++;
    endtask

    task automatic send_group(input cg_t cg);
        @(posedge clk_receptor);
        sudi_receive    <= cg;
        rx_even_receive <= odd;
        odd = !odd;
    endtask

    task automatic send_idles(input int sets);
        if (odd) send_group(D16_2);                 // Realign to an even K28.5
        repeat (sets) begin
            send_group(`K28_5_NEG);
            send_group(D16_2);
        end
    endtask

    task automatic run_packet(input string name, input int len, input bit mixed,
                              input bit drop_sync);
        octet_q_t data;
        cg_t      cgs[$];
        int       idx;
        int       start;
        int       n;
        for (int i = 0; i < len; i++) begin
            idx = $urandom % 13;
            cgs.push_back((mixed && $urandom % 2) ? CG_POS[idx] : CG_NEG[idx]);
            data.push_back(OCT[idx]);
        end
        chk0.expect_burst(name, drop_sync, expected_burst(data));
        start = chk0.bursts_done;
        if ((int'(odd) + len + 3) % 2) send_group(D16_2);  // End comma on even
        send_group(K27_7);
        foreach (cgs[i]) begin
            send_group(cgs[i]);
            if (drop_sync && i == len / 2) sync_status <= 1'b0;
            if (drop_sync && i == len / 2 + 2) sync_status <= 1'b1;
        end
        send_group(K29_7);
        send_group(K23_7);
        send_group(`K28_5_NEG);
        for (n = 0; n < 20 && chk0.bursts_done == start; n++) send_idles(1);
        if (chk0.bursts_done == start) report_timeout({"end of burst in ", name});
        send_idles(2);
    endtask

    initial begin
        sync_status     = 1'b1;
        sudi_receive    = '0;
        rx_even_receive = 1'b0;
        void'($urandom(32'hedcd));
        for (int i = 0; i < 20 && rst_n !== 1'b1; i++) @(posedge clk_receptor);
        if (rst_n !== 1'b1) report_timeout("reset release");

        send_idles(6);
        chk0.check_value("reset_idle", "rx_dv cycles", 0, chk0.dv_cycles);
        chk0.check_value("reset_idle", "rx_er cycles", 0, chk0.er_cycles);
        chk0.check_value("reset_idle", "nonzero rxd cycles", 0, chk0.rxd_busy_cycles);
        chk0.end_test("reset_idle");

        run_packet("single_packet", 6, 1'b0, 1'b0);
        chk0.end_test("single_packet");

        repeat (8) run_packet("random_packets", 1 + $urandom % 16, 1'b1, 1'b0);
        chk0.end_test("random_packets");

        mark = chk0.bursts_done;
        repeat (3) run_packet("back_to_back", 1 + $urandom % 16, 1'b1, 1'b0);
        chk0.check_value("back_to_back", "bursts", 3, chk0.bursts_done - mark);
        chk0.end_test("back_to_back");

        mark = chk0.er_cycles;
        run_packet("sync_loss", 8, 1'b1, 1'b1);
        chk0.check_value("sync_loss", "rx_er cycles", 1, chk0.er_cycles - mark);
        run_packet("sync_loss", 5, 1'b1, 1'b0);
        chk0.end_test("sync_loss");

        mark = chk0.dv_cycles;
        repeat (16) send_group(odd ? 10'b0101010101 : 10'b1010101010);
        send_idles(2);
        chk0.check_value("unknown_groups", "rx_dv cycles", 0, chk0.dv_cycles - mark);
        chk0.end_test("unknown_groups");

        chk0.report_counts();
        if (chk0.n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- receptor.f
+incdir+design
design/receptor_pkg.sv
design/code_group_decoder.sv
design/code_group_history.sv
design/receive_fsm.sv
design/receptor.sv
dv/receptor_properties.sv
dv/receptor_clock.sv
dv/receptor_checker.sv
dv/tb_receptor.sv

//--- run_receptor.sh
#!/bin/sh
# Build and run the receptor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_receptor \
    -f receptor.f -Mdir build_receptor -o sim_receptor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build_receptor/sim_receptor > sim_receptor.log 2>&1
run_status=$?
cat sim_receptor.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST OK" sim_receptor.log; then
    exit 0
fi
exit 1
